// File: hw/matrix_mod_macros.svh
`ifndef MATRIX_MOD_MACROS_SVH
`define MATRIX_MOD_MACROS_SVH

// Element and modulus width
`define MM_DATA_W 32
// Reduction lanes behind the dispatcher
`define MM_LANES 4
// Row or column count width
`define MM_DIM_W 6
// Input FIFO entries, also host credits after reset (power of two)
`define MM_IN_DEPTH 4
// Operand and result slots per lane
`define MM_LANE_DEPTH 1
// Sink credit counter width
`define MM_OUT_CRED_W 4

`endif

// File: hw/matrix_mod_pkg.sv
`default_nettype none

`include "matrix_mod_macros.svh"

package matrix_mod_pkg;

  ////////////////////
  // Data words
  ////////////////////

  // One element or modulus
  typedef logic [`MM_DATA_W-1:0] elem_t;

  // Row or column count, or index inside the matrix
  typedef logic [`MM_DIM_W-1:0] dim_t;

  ////////////////////
  // Lane selection
  ////////////////////

  // Round-robin pointer, at least one bit even for a single lane
  typedef logic [(`MM_LANES > 1 ? $clog2(`MM_LANES) : 1)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: hw/lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lane_if
  import matrix_mod_pkg::*;
();

  // Operand link, dispatcher to lane
  logic  op_valid;
  elem_t op_data;
  elem_t op_mod;
  logic  op_last;
  // Operand slot freed
  logic  op_credit;

  // Result link, lane to collector
  logic  res_valid;
  elem_t res_data;
  logic  res_last;
  // Collector slot freed
  logic  res_credit;

  modport feeder (output op_valid, op_data, op_mod, op_last, input op_credit);

  modport lane (
    input  op_valid, op_data, op_mod, op_last, res_credit,
    output op_credit, res_valid, res_data, res_last
  );

  modport drain (input res_valid, res_data, res_last, output res_credit);

endinterface

`default_nettype wire

// File: hw/elem_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module elem_dispatch
  import matrix_mod_pkg::*;
(
  input  logic   CLK,
  input  logic   RST,
  input  logic   start,
  input  logic   in_valid,
  input  elem_t  modulus,
  input  dim_t   size_i,
  input  dim_t   size_j,
  input  elem_t  in_data,
  output logic   in_credit,
  lane_if.feeder lanes [`MM_LANES]
);

  localparam int FW = $clog2(`MM_IN_DEPTH);
  localparam int CW = $clog2(`MM_LANE_DEPTH + 1);

  typedef enum logic [1:0] {S_IDLE, S_RUN, S_DRAIN, S_DONE} state_t;

  state_t state;
  // Latched job
  elem_t mod_q;
  dim_t  last_i;
  dim_t  last_j;
  // Raster position of the next issued element
  dim_t  row;
  dim_t  col;
  // Input FIFO
  elem_t         fifo [`MM_IN_DEPTH];
  logic [FW-1:0] wr_ptr;
  logic [FW-1:0] rd_ptr;
  logic [FW:0]   fill;
  // Lane side
  lane_idx_t            rr;
  logic [CW-1:0]        cred [`MM_LANES];
  logic [`MM_LANES-1:0] op_valid;
  logic [`MM_LANES-1:0] op_credit;
  elem_t                op_data;
  logic                 op_last;
  logic                 issue;
  logic                 last_elem;
  logic                 all_home;
  logic                 job_open;

  // One operand bus shared by all lanes, valid picks the lane
  for (genvar g = 0; g < `MM_LANES; g++) begin : g_lane
    assign lanes[g].op_valid = op_valid[g];
    assign lanes[g].op_data  = op_data;
    assign lanes[g].op_mod   = mod_q;
    assign lanes[g].op_last  = op_last;
    assign op_credit[g]      = lanes[g].op_credit;
  end

  ////////////////////
  // Job control
  ////////////////////

  // New job may start once the previous one has drained out of the lanes
  assign job_open  = (state == S_IDLE) || (state == S_DONE);
  assign issue     = (state == S_RUN) && (fill != '0) && (cred[rr] != '0);
  assign last_elem = (row == last_i) && (col == last_j);

  always_comb begin
    all_home = 1'b1;
    for (int i = 0; i < `MM_LANES; i++) begin
      if (cred[i] != CW'(`MM_LANE_DEPTH))
        all_home = 1'b0;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= S_IDLE;
      row   <= '0;
      col   <= '0;
    end else begin
      case (state)
        S_IDLE, S_DONE: begin
          state <= start ? S_RUN : S_IDLE;
          row   <= '0;
          col   <= '0;
        end
        S_RUN: begin
          if (issue) begin
            if (last_elem) begin
              state <= S_DRAIN;
            end else if (col == last_j) begin
              // Wrap to next row
              col <= '0;
              row <= row + 1'b1;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        // Wait for every lane to hand its operand slot back
        S_DRAIN: if (all_home) state <= S_DONE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Store end indices rather than sizes
  always_ff @(posedge CLK) begin
    if (start && job_open) begin
      mod_q  <= modulus;
      last_i <= size_i - 1'b1;
      last_j <= size_j - 1'b1;
    end
  end

  ////////////////////
  // Input FIFO
  ////////////////////

  always_ff @(posedge CLK) begin
    if (in_valid)
      fifo[wr_ptr] <= in_data;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (in_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (issue)
        rd_ptr <= rd_ptr + 1'b1;
      case ({in_valid, issue})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  ////////////////////
  // Round-robin issue
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      op_valid  <= '0;
      in_credit <= 1'b0;
      rr        <= '0;
      for (int i = 0; i < `MM_LANES; i++)
        cred[i] <= CW'(`MM_LANE_DEPTH);
    end else begin
      op_valid <= '0;
      // FIFO slot freed, host may send one more
      in_credit <= issue;
      if (issue) begin
        op_valid[rr] <= 1'b1;
        rr <= (rr == lane_idx_t'(`MM_LANES - 1)) ? '0 : rr + 1'b1;
      end
      for (int i = 0; i < `MM_LANES; i++) begin
        case ({issue && (rr == lane_idx_t'(i)), op_credit[i]})
          2'b10:   cred[i] <= cred[i] - 1'b1;
          2'b01:   cred[i] <= cred[i] + 1'b1;
          default: cred[i] <= cred[i];
        endcase
      end
    end
  end

  // Operand payload, read only with op_valid
  always_ff @(posedge CLK) begin
    if (issue) begin
      op_data <= fifo[rd_ptr];
      op_last <= last_elem;
    end
  end

  // Host must respect its credits
  a_no_overrun: assert property (@(posedge CLK) disable iff (RST)
    in_valid |-> (fill != (FW+1)'(`MM_IN_DEPTH)));

  // Host waits for BUSY low, so no START lands mid-job
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    start |-> job_open);

endmodule

`default_nettype wire

// File: hw/mod_reduce_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module mod_reduce_lane
  import matrix_mod_pkg::*;
(
  input logic  CLK,
  input logic  RST,
  lane_if.lane lnk
);

  localparam int SW = $clog2(`MM_DATA_W);
  localparam int CW = $clog2(`MM_LANE_DEPTH + 1);

  typedef enum logic [1:0] {E_IDLE, E_CALC, E_DONE} eng_t;

  eng_t          state;
  logic [SW-1:0] step;
  // Divider datapath
  elem_t              dvd;
  elem_t              rem;
  elem_t              modr;
  logic               last_q;
  logic [`MM_DATA_W:0] shifted;
  elem_t              diff;
  logic               fits;
  elem_t              result;
  // Result slot and collector credits
  logic          slot_full;
  elem_t         slot_data;
  logic          slot_last;
  logic [CW-1:0] res_cred;
  logic          retire;
  logic          send_new;
  logic          send_old;

  ////////////////////
  // Restoring step
  ////////////////////

  // Next dividend bit into the partial remainder
  assign shifted = {rem, dvd[`MM_DATA_W-1]};
  assign fits    = shifted >= {1'b0, modr};
  // Low bits suffice, the true difference is below the modulus
  assign diff    = shifted[`MM_DATA_W-1:0] - modr;
  // Dividend has rotated back to the original after all steps
  assign result  = (modr == '0) ? dvd : rem;

  assign retire   = (state == E_DONE) && !slot_full;
  assign send_new = retire && (res_cred != '0);
  assign send_old = slot_full && (res_cred != '0);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= E_IDLE;
      step  <= '0;
    end else begin
      case (state)
        E_IDLE: begin
          step <= '0;
          if (lnk.op_valid)
            state <= E_CALC;
        end
        E_CALC: begin
          step <= step + 1'b1;
          if (step == SW'(`MM_DATA_W - 1))
            state <= E_DONE;
        end
        // Result cycle, stalls while the slot is occupied
        E_DONE: if (retire) state <= E_IDLE;
        default: state <= E_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == E_IDLE) && lnk.op_valid) begin
      dvd    <= lnk.op_data;
      modr   <= lnk.op_mod;
      last_q <= lnk.op_last;
      rem    <= '0;
    end else if (state == E_CALC) begin
      dvd <= {dvd[`MM_DATA_W-2:0], dvd[`MM_DATA_W-1]};
      rem <= fits ? diff : shifted[`MM_DATA_W-1:0];
    end
  end

  ////////////////////
  // Result side
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      lnk.res_valid <= 1'b0;
      lnk.op_credit <= 1'b0;
      slot_full     <= 1'b0;
      res_cred      <= CW'(`MM_LANE_DEPTH);
    end else begin
      lnk.res_valid <= send_new || send_old;
      // Operand slot is free once its result has left the divider
      lnk.op_credit <= retire;
      if (send_old)
        slot_full <= 1'b0;
      else if (retire && !send_new)
        slot_full <= 1'b1;
      case ({send_new || send_old, lnk.res_credit})
        2'b10:   res_cred <= res_cred - 1'b1;
        2'b01:   res_cred <= res_cred + 1'b1;
        default: res_cred <= res_cred;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (send_new) begin
      lnk.res_data <= result;
      lnk.res_last <= last_q;
    end else if (send_old) begin
      lnk.res_data <= slot_data;
      lnk.res_last <= slot_last;
    end
    // Parked until the collector returns a credit
    if (retire && !send_new) begin
      slot_data <= result;
      slot_last <= last_q;
    end
  end

  // Collector never returns a credit it does not owe
  a_res_credit: assert property (@(posedge CLK) disable iff (RST)
    lnk.res_credit |-> (res_cred != CW'(`MM_LANE_DEPTH)));

endmodule

`default_nettype wire

// File: hw/elem_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module elem_collect
  import matrix_mod_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  start,
  lane_if.drain lanes [`MM_LANES],
  input  logic  out_credit,
  output logic  out_valid,
  output logic  out_last,
  output elem_t out_data,
  output logic  busy
);

  // Per-lane receive buffers
  logic [`MM_LANES-1:0] res_valid;
  logic [`MM_LANES-1:0] res_last;
  logic [`MM_LANES-1:0] res_credit;
  elem_t                res_data [`MM_LANES];
  logic [`MM_LANES-1:0] held;
  logic [`MM_LANES-1:0] held_last;
  elem_t                held_data [`MM_LANES];
  // Sink side
  logic [`MM_OUT_CRED_W-1:0] sink_cred;
  lane_idx_t                 ptr;
  logic                      drain;

  for (genvar g = 0; g < `MM_LANES; g++) begin : g_lane
    assign res_valid[g]       = lanes[g].res_valid;
    assign res_data[g]        = lanes[g].res_data;
    assign res_last[g]        = lanes[g].res_last;
    assign lanes[g].res_credit = res_credit[g];
  end

  ////////////////////
  // Ordered drain
  ////////////////////

  // Same lane order as the dispatcher, so raster order comes back
  assign drain = held[ptr] && (sink_cred != '0);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      held       <= '0;
      res_credit <= '0;
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
      ptr        <= '0;
      sink_cred  <= '0;
    end else begin
      res_credit <= '0;
      out_valid  <= drain;
      out_last   <= drain && held_last[ptr];
      if (drain) begin
        held[ptr]       <= 1'b0;
        res_credit[ptr] <= 1'b1;
        ptr <= (ptr == lane_idx_t'(`MM_LANES - 1)) ? '0 : ptr + 1'b1;
      end
      // A lane refills only after its credit, never in the drain cycle
      for (int i = 0; i < `MM_LANES; i++) begin
        if (res_valid[i])
          held[i] <= 1'b1;
      end
      case ({out_credit, drain})
        2'b10:   sink_cred <= sink_cred + 1'b1;
        2'b01:   sink_cred <= sink_cred - 1'b1;
        default: sink_cred <= sink_cred;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (drain)
      out_data <= held_data[ptr];
    for (int i = 0; i < `MM_LANES; i++) begin
      if (res_valid[i]) begin
        held_data[i] <= res_data[i];
        held_last[i] <= res_last[i];
      end
    end
  end

  ////////////////////
  // Job status
  ////////////////////

  // High from START until the element flagged last has gone out
  always_ff @(posedge CLK or posedge RST) begin
    if (RST)
      busy <= 1'b0;
    else if (out_valid && out_last)
      busy <= 1'b0;
    else if (start)
      busy <= 1'b1;
  end

  // Sink grants no more credits than the counter holds
  a_sink_cred: assert property (@(posedge CLK) disable iff (RST)
    (out_credit && !drain) |-> (sink_cred != '1));

endmodule

`default_nettype wire

// File: hw/matrix_mod_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module matrix_mod_top
  import matrix_mod_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  // Job control
  input  logic  START,
  input  elem_t MODULUS,
  input  dim_t  SIZE_I,
  input  dim_t  SIZE_J,
  output logic  BUSY,
  // Host element stream
  input  logic  IN_VALID,
  input  elem_t IN_DATA,
  output logic  IN_CREDIT,
  // Reduced element stream
  output logic  OUT_VALID,
  output elem_t OUT_DATA,
  output logic  OUT_LAST,
  input  logic  OUT_CREDIT
);

  // One link per lane
  lane_if lane_bus [`MM_LANES] ();

  ////////////////////
  // Front end
  ////////////////////

  elem_dispatch u_dispatch (
    .CLK       (CLK),
    .RST       (RST),
    .start     (START),
    .in_valid  (IN_VALID),
    .modulus   (MODULUS),
    .size_i    (SIZE_I),
    .size_j    (SIZE_J),
    .in_data   (IN_DATA),
    .in_credit (IN_CREDIT),
    .lanes     (lane_bus)
  );

  ////////////////////
  // Reduction lanes
  ////////////////////

  for (genvar g = 0; g < `MM_LANES; g++) begin : g_lane
    mod_reduce_lane u_lane (
      .CLK (CLK),
      .RST (RST),
      .lnk (lane_bus[g])
    );
  end

  ////////////////////
  // Back end
  ////////////////////

  elem_collect u_collect (
    .CLK        (CLK),
    .RST        (RST),
    .start      (START),
    .lanes      (lane_bus),
    .out_credit (OUT_CREDIT),
    .out_valid  (OUT_VALID),
    .out_last   (OUT_LAST),
    .out_data   (OUT_DATA),
    .busy       (BUSY)
  );

endmodule

`default_nettype wire

// File: sim/mod_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module mod_checker
  import matrix_mod_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  // DUT output stream
  input  logic  out_valid,
  input  elem_t out_data,
  input  logic  out_last,
  // Expected values from the stimulus
  input  logic  exp_push,
  input  elem_t exp_data,
  input  logic  exp_last,
  // Error counts and outstanding expectations
  output int    data_errs,
  output int    last_errs,
  output int    extra_errs,
  output int    pending
);

  // Expected stream, raster order
  elem_t want_data_q [$];
  logic  want_last_q [$];
  elem_t want_data;
  logic  want_last;
  int    n_data = 0;
  int    n_last = 0;
  int    n_extra = 0;
  int    n_pending = 0;
  int    seen = 0;

  assign data_errs  = n_data;
  assign last_errs  = n_last;
  assign extra_errs = n_extra;
  assign pending    = n_pending;

  always @(posedge CLK) begin
    // Queue first, an output never arrives in its own push cycle
    if (exp_push) begin
      want_data_q.push_back(exp_data);
      want_last_q.push_back(exp_last);
    end
    if (!RST && out_valid) begin
      if (want_data_q.size() == 0) begin
        n_extra++;
        $display("Unexpected output %h with nothing left to expect", out_data);
      end else begin
        want_data = want_data_q.pop_front();
        want_last = want_last_q.pop_front();
        if (out_data !== want_data) begin
          n_data++;
          $display("** Error OUT_DATA element %0d: expected %h, got %h",
                   seen, want_data, out_data);
        end
        // Final element of a job without its flag
        if (want_last && !out_last) begin
          n_last++;
          $display("Last flag missing on output element %0d", seen);
        end else if (out_last !== want_last) begin
          n_last++;
          $display("** Error OUT_LAST element %0d: expected %h, got %h",
                   seen, want_last, out_last);
        end
      end
      seen++;
    end
    n_pending = want_data_q.size();
  end

endmodule

`default_nettype wire

// File: sim/tb_matrix_mod.sv
`timescale 1ns/1ps
`default_nettype none

`include "matrix_mod_macros.svh"

module tb_matrix_mod
  import matrix_mod_pkg::*;
();

  localparam logic [31:0] SEED = 32'h217f0865;
  localparam int DEPTH = `MM_IN_DEPTH;
  // Sum of all job sizes below
  localparam int TOTAL_ELEMS = 3*5 + 4*4 + 2*3 + 3*3 + 1*1 + 3*7 + 5*6 + 2*9;
  localparam int LIMIT = TOTAL_ELEMS * (`MM_DATA_W + 2) * 4 + 2000;
  // Sink credits in flight, well below the collector counter range
  localparam int SINK_MAX = 8;

  logic  CLK;
  logic  RST;
  logic  START;
  elem_t MODULUS;
  dim_t  SIZE_I;
  dim_t  SIZE_J;
  logic  BUSY;
  logic  IN_VALID;
  elem_t IN_DATA;
  logic  IN_CREDIT;
  logic  OUT_VALID;
  elem_t OUT_DATA;
  logic  OUT_LAST;
  logic  OUT_CREDIT;
  // Expected stream into the checker
  logic  exp_push;
  elem_t exp_data;
  logic  exp_last;
  int    data_errs;
  int    last_errs;
  int    extra_errs;
  int    pending;
  // Stimulus state
  logic [31:0] rnd;
  int          host_cred;
  int          tb_errs;
  logic        sink_gaps;
  int          cycles = 0;

  matrix_mod_top DUT (
    .CLK(CLK), .RST(RST), .START(START), .MODULUS(MODULUS), .SIZE_I(SIZE_I),
    .SIZE_J(SIZE_J), .BUSY(BUSY), .IN_VALID(IN_VALID), .IN_DATA(IN_DATA),
    .IN_CREDIT(IN_CREDIT), .OUT_VALID(OUT_VALID), .OUT_DATA(OUT_DATA),
    .OUT_LAST(OUT_LAST), .OUT_CREDIT(OUT_CREDIT)
  );

  mod_checker u_check (
    .CLK(CLK), .RST(RST), .out_valid(OUT_VALID), .out_data(OUT_DATA),
    .out_last(OUT_LAST), .exp_push(exp_push), .exp_data(exp_data),
    .exp_last(exp_last), .data_errs(data_errs), .last_errs(last_errs),
    .extra_errs(extra_errs), .pending(pending)
  );

  ////////////////////
  // Models
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Remainder, zero modulus passes the element through
  function automatic elem_t ref_mod(input elem_t data, input elem_t m);
    if (m == '0)
      return data;
    return data % m;
  endfunction

  ////////////////////
  // Host side
  ////////////////////

  // Next falling edge, collect a returned FIFO credit
  task automatic step_host();
    @(negedge CLK);
    if (IN_CREDIT)
      host_cred++;
    if (host_cred > DEPTH) begin
      tb_errs++;
      $display("Host holds %0d credits, more than FIFO depth %0d", host_cred, DEPTH);
    end
  endtask

  task automatic run_job(input dim_t si, input dim_t sj, input elem_t modv,
                         input elem_t mask, input logic gaps);
    int    n;
    elem_t d;
    n = int'(si) * int'(sj);
    sink_gaps = gaps;
    while (BUSY)
      step_host();
    START   = 1'b1;
    MODULUS = modv;
    SIZE_I  = si;
    SIZE_J  = sj;
    step_host();
    START = 1'b0;
    if (BUSY !== 1'b1) begin
      tb_errs++;
      $display("BUSY did not rise after START");
    end
    for (int k = 0; k < n; k++) begin
      while (host_cred == 0)
        step_host();
      rnd      = lcg_next(rnd);
      d        = rnd & mask;
      IN_VALID = 1'b1;
      IN_DATA  = d;
      exp_push = 1'b1;
      exp_data = ref_mod(d, modv);
      exp_last = (k == n - 1);
      host_cred--;
      step_host();
      IN_VALID = 1'b0;
      exp_push = 1'b0;
      // Idle host cycles now and then under back-pressure
      if (gaps && rnd[7:6] == 2'b00)
        step_host();
    end
    while (BUSY)
      step_host();
    if (pending != 0) begin
      tb_errs++;
      $display("BUSY fell with %0d elements still missing", pending);
    end
  endtask

  ////////////////////
  // Clock and sink
  ////////////////////

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // Sink credit source, gaps only while back-pressure is on
  initial begin
    int          owed;
    logic [31:0] srnd;
    owed       = 0;
    srnd       = SEED;
    OUT_CREDIT = 1'b0;
    forever begin
      @(negedge CLK);
      if (OUT_VALID)
        owed--;
      srnd       = lcg_next(srnd);
      OUT_CREDIT = 1'b0;
      if (!RST && owed < SINK_MAX && (!sink_gaps || srnd[31:30] == 2'b00)) begin
        OUT_CREDIT = 1'b1;
        owed++;
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, the jobs did not finish", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    RST       = 1'b1;
    START     = 1'b0;
    MODULUS   = '0;
    SIZE_I    = '0;
    SIZE_J    = '0;
    IN_VALID  = 1'b0;
    IN_DATA   = '0;
    exp_push  = 1'b0;
    exp_data  = '0;
    exp_last  = 1'b0;
    rnd       = SEED;
    host_cred = DEPTH;
    tb_errs   = 0;
    sink_gaps = 1'b0;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    step_host();
    if (BUSY !== 1'b0 || IN_CREDIT !== 1'b0 || OUT_VALID !== 1'b0 || OUT_LAST !== 1'b0) begin
      tb_errs++;
      $display("Status outputs not idle after reset");
    end
    // Raster order, random modulus
    rnd = lcg_next(rnd);
    run_job(6'd3, 6'd5, (rnd & 32'h000f_ffff) | 32'h1, '1, 1'b0);
    // Corner moduli
    run_job(6'd4, 6'd4, 32'h0, '1, 1'b0);
    run_job(6'd2, 6'd3, 32'h1, '1, 1'b0);
    run_job(6'd3, 6'd3, 32'hffff_ffff, 32'h7fff_ffff, 1'b0);
    // Odd sizes against the lane count
    rnd = lcg_next(rnd);
    run_job(6'd1, 6'd1, rnd | 32'h1, '1, 1'b0);
    rnd = lcg_next(rnd);
    run_job(6'd3, 6'd7, (rnd & 32'h0000_ffff) | 32'h1, '1, 1'b0);
    // Sink back-pressure
    rnd = lcg_next(rnd);
    run_job(6'd5, 6'd6, (rnd & 32'h00ff_ffff) | 32'h1, '1, 1'b1);
    // Started right after BUSY fell, new sizes
    rnd = lcg_next(rnd);
    run_job(6'd2, 6'd9, rnd | 32'h1, 32'h0fff_ffff, 1'b0);
    $display("Errors: data %0d, last %0d, unexpected %0d, pending %0d, host %0d",
             data_errs, last_errs, extra_errs, pending, tb_errs);
    if (data_errs + last_errs + extra_errs + tb_errs == 0 && pending == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/matrix_mod_pkg.sv
hw/lane_if.sv
hw/elem_dispatch.sv
hw/mod_reduce_lane.sv
hw/elem_collect.sv
hw/matrix_mod_top.sv
sim/mod_checker.sv
sim/tb_matrix_mod.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_matrix_mod
RTL_TOP   ?= matrix_mod_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0
PASS_MSG  ?= TB PASSED

SRCS := $(wildcard hw/*.sv hw/*.svh sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
